// File: trace_pkg.sv
/* Shared widths, RV32I major opcode encodings and trace record classes */

package trace_pkg;

  localparam int unsigned xlen       = 32;
  localparam int unsigned reg_addr_w = 5;
  // retire counter, wraps
  localparam int unsigned count_w    = 16;

  // RV32I major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011,
    op_fence  = 7'b0001111,
    op_system = 7'b1110011
  } opcode_e;

  // class stored with each retired record
  typedef enum logic [3:0] {
    cls_lui,
    cls_auipc,
    cls_jal,
    cls_jalr,
    cls_branch,
    cls_load,
    cls_store,
    cls_alu_imm,
    cls_alu_reg,
    cls_fence,
    cls_csr,
    cls_system,
    cls_invalid
  } instr_class_e;

endpackage

// File: instr_classifier.sv
/* Decode trigger, opcode to record class mapping and rd field extraction,
   with registered issue outputs */
`timescale 1ns/1ps

module instr_classifier import trace_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  id_valid,
  input  logic                  is_decoding,
  input  logic [xlen-1:0]       pc,
  input  logic [xlen-1:0]       instr,
  output logic                  issue,
  output logic [xlen-1:0]       issue_pc,
  output instr_class_e          issue_cls,
  output logic [reg_addr_w-1:0] issue_rd
);

  opcode_e               opcode;
  instr_class_e          cls;
  logic [reg_addr_w-1:0] rd;
  logic                  trigger;

  assign opcode  = opcode_e'(instr[6:0]);
  assign trigger = id_valid && is_decoding;

  // major opcode to class
  always_comb begin
    case (opcode)
      op_lui:    cls = cls_lui;
      op_auipc:  cls = cls_auipc;
      op_jal:    cls = cls_jal;
      op_jalr:   cls = cls_jalr;
      op_branch: cls = cls_branch;
      op_load:   cls = cls_load;
      op_store:  cls = cls_store;
      op_imm:    cls = cls_alu_imm;
      op_reg:    cls = cls_alu_reg;
      op_fence:  cls = cls_fence;
      // funct3 zero covers ecall, ebreak, xret and wfi
      op_system: cls = (instr[14:12] == 3'b000) ? cls_system : cls_csr;
      default:   cls = cls_invalid;
    endcase
  end

  // only classes that write a register keep rd
  always_comb begin
    case (cls)
      cls_lui, cls_auipc, cls_jal, cls_jalr, cls_load,
      cls_alu_imm, cls_alu_reg, cls_csr: rd = instr[11:7];
      default:                           rd = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issue <= 1'b0;
    end else begin
      issue <= trigger;
    end
  end

  always_ff @(posedge clk) begin
    if (trigger) begin
      issue_pc  <= pc;
      issue_cls <= cls;
      issue_rd  <= rd;
    end
  end

endmodule

// File: trace_ex_stage.sv
/* Shadow EX stage: in-flight record queue with register write-back and
   granted data access capture at its head */
`timescale 1ns/1ps

module trace_ex_stage import trace_pkg::*; #(
  parameter int unsigned ex_depth = 4
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  issue,
  input  logic [xlen-1:0]       issue_pc,
  input  instr_class_e          issue_cls,
  input  logic [reg_addr_w-1:0] issue_rd,
  input  logic                  ex_valid,
  input  logic                  wb_bypass,
  input  logic                  ex_reg_we,
  input  logic [reg_addr_w-1:0] ex_reg_addr,
  input  logic [xlen-1:0]       ex_reg_wdata,
  input  logic                  ex_data_req,
  input  logic                  ex_data_gnt,
  input  logic [xlen-1:0]       ex_data_addr,
  output logic                  hand_off,
  output logic [xlen-1:0]       ho_pc,
  output instr_class_e          ho_cls,
  output logic [reg_addr_w-1:0] ho_rd_addr,
  output logic [xlen-1:0]       ho_rd_value,
  output logic                  ho_mem_hit,
  output logic [xlen-1:0]       ho_mem_addr
);

  localparam int unsigned ptr_w = (ex_depth > 1) ? $clog2(ex_depth) : 1;
  localparam int unsigned cnt_w = $clog2(ex_depth + 1);

  logic [xlen-1:0]       q_pc       [ex_depth];
  instr_class_e          q_cls      [ex_depth];
  logic [reg_addr_w-1:0] q_rd_addr  [ex_depth];
  logic [xlen-1:0]       q_rd_value [ex_depth];
  logic                  q_mem_hit  [ex_depth];
  logic [xlen-1:0]       q_mem_addr [ex_depth];

  logic [ptr_w-1:0] head;
  logic [ptr_w-1:0] tail;
  logic [cnt_w-1:0] count;
  logic             not_empty;
  logic             reg_hit;
  logic             mem_grant;

  assign not_empty = (count != '0);
  assign reg_hit   = ex_reg_we && (q_rd_addr[head] != '0) && (ex_reg_addr == q_rd_addr[head]);
  assign mem_grant = ex_data_req && ex_data_gnt;

  //////////////////////////////
  // head record, with this cycle's capture folded in
  assign hand_off    = not_empty && (ex_valid || wb_bypass);
  assign ho_pc       = q_pc[head];
  assign ho_cls      = q_cls[head];
  assign ho_rd_addr  = q_rd_addr[head];
  assign ho_rd_value = reg_hit ? ex_reg_wdata : q_rd_value[head];
  assign ho_mem_hit  = mem_grant || q_mem_hit[head];
  assign ho_mem_addr = mem_grant ? ex_data_addr : q_mem_addr[head];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (issue) begin
        tail <= (tail == ptr_w'(ex_depth - 1)) ? '0 : tail + 1'b1;
      end
      if (hand_off) begin
        head <= (head == ptr_w'(ex_depth - 1)) ? '0 : head + 1'b1;
      end
      if (issue && !hand_off) begin
        count <= count + 1'b1;
      end else if (hand_off && !issue) begin
        count <= count - 1'b1;
      end
    end
  end

  // issue write last, so it wins when a full queue issues and hands off at once
  always_ff @(posedge clk) begin
    if (not_empty) begin
      q_rd_value[head] <= ho_rd_value;
      q_mem_hit[head]  <= ho_mem_hit;
      q_mem_addr[head] <= ho_mem_addr;
    end
    if (issue) begin
      q_pc[tail]       <= issue_pc;
      q_cls[tail]      <= issue_cls;
      q_rd_addr[tail]  <= issue_rd;
      q_rd_value[tail] <= '0;
      q_mem_hit[tail]  <= 1'b0;
      q_mem_addr[tail] <= '0;
    end
  end

  // the decoder has no stall path, so a full queue must drain in the same cycle
  a_ex_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    (issue && count == cnt_w'(ex_depth)) |-> hand_off)
    else $error("EX trace queue overflow on issue");

endmodule

// File: trace_wb_stage.sv
/* Shadow WB stage: in-flight record queue with write-back capture, registered
   retire strobe, buffer write index and retire counter */
`timescale 1ns/1ps

module trace_wb_stage import trace_pkg::*; #(
  parameter int unsigned wb_depth  = 4,
  parameter int unsigned buf_depth = 16
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         hand_off,
  input  logic [xlen-1:0]              ho_pc,
  input  instr_class_e                 ho_cls,
  input  logic [reg_addr_w-1:0]        ho_rd_addr,
  input  logic [xlen-1:0]              ho_rd_value,
  input  logic                         ho_mem_hit,
  input  logic [xlen-1:0]              ho_mem_addr,
  input  logic                         wb_valid,
  input  logic                         wb_reg_we,
  input  logic [reg_addr_w-1:0]        wb_reg_addr,
  input  logic [xlen-1:0]              wb_reg_wdata,
  output logic                         retire,
  output logic [$clog2(buf_depth)-1:0] retire_idx,
  output logic [xlen-1:0]              ret_pc,
  output instr_class_e                 ret_cls,
  output logic [reg_addr_w-1:0]        ret_rd_addr,
  output logic [xlen-1:0]              ret_rd_value,
  output logic                         ret_mem_hit,
  output logic [xlen-1:0]              ret_mem_addr,
  output logic [count_w-1:0]           trace_count
);

  localparam int unsigned ptr_w = (wb_depth > 1) ? $clog2(wb_depth) : 1;
  localparam int unsigned cnt_w = $clog2(wb_depth + 1);
  localparam int unsigned idx_w = $clog2(buf_depth);

  logic [xlen-1:0]       q_pc       [wb_depth];
  instr_class_e          q_cls      [wb_depth];
  logic [reg_addr_w-1:0] q_rd_addr  [wb_depth];
  logic [xlen-1:0]       q_rd_value [wb_depth];
  logic                  q_mem_hit  [wb_depth];
  logic [xlen-1:0]       q_mem_addr [wb_depth];

  logic [ptr_w-1:0] head;
  logic [ptr_w-1:0] tail;
  logic [cnt_w-1:0] count;
  logic             not_empty;
  logic             pop;
  logic             reg_hit;
  logic [xlen-1:0]  head_rd_value;

  assign not_empty     = (count != '0);
  assign pop           = not_empty && wb_valid;
  assign reg_hit       = wb_reg_we && (q_rd_addr[head] != '0) && (wb_reg_addr == q_rd_addr[head]);
  assign head_rd_value = reg_hit ? wb_reg_wdata : q_rd_value[head];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head        <= '0;
      tail        <= '0;
      count       <= '0;
      retire      <= 1'b0;
      trace_count <= '0;
    end else begin
      retire <= pop;
      if (hand_off) begin
        tail <= (tail == ptr_w'(wb_depth - 1)) ? '0 : tail + 1'b1;
      end
      if (pop) begin
        head        <= (head == ptr_w'(wb_depth - 1)) ? '0 : head + 1'b1;
        trace_count <= trace_count + 1'b1;
      end
      if (hand_off && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !hand_off) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (not_empty) begin
      q_rd_value[head] <= head_rd_value;
    end
    if (hand_off) begin
      q_pc[tail]       <= ho_pc;
      q_cls[tail]      <= ho_cls;
      q_rd_addr[tail]  <= ho_rd_addr;
      q_rd_value[tail] <= ho_rd_value;
      q_mem_hit[tail]  <= ho_mem_hit;
      q_mem_addr[tail] <= ho_mem_addr;
    end
  end

  //////////////////////////////
  // retired record, index is the count before the increment
  always_ff @(posedge clk) begin
    if (pop) begin
      retire_idx   <= trace_count[idx_w-1:0];
      ret_pc       <= q_pc[head];
      ret_cls      <= q_cls[head];
      ret_rd_addr  <= q_rd_addr[head];
      ret_rd_value <= head_rd_value;
      ret_mem_hit  <= q_mem_hit[head];
      ret_mem_addr <= q_mem_addr[head];
    end
  end

  a_wb_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    (hand_off && count == cnt_w'(wb_depth)) |-> pop)
    else $error("WB trace queue overflow on hand-off");

endmodule

// File: trace_arbiter.sv
/* Trace buffer port arbiter: retire writes first, one pending host read */
`timescale 1ns/1ps

module trace_arbiter import trace_pkg::*; #(
  parameter int unsigned buf_depth = 16
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         retire,
  input  logic [$clog2(buf_depth)-1:0] retire_idx,
  input  logic [xlen-1:0]              ret_pc,
  input  instr_class_e                 ret_cls,
  input  logic [reg_addr_w-1:0]        ret_rd_addr,
  input  logic [xlen-1:0]              ret_rd_value,
  input  logic                         ret_mem_hit,
  input  logic [xlen-1:0]              ret_mem_addr,
  input  logic                         rd_req,
  input  logic [$clog2(buf_depth)-1:0] rd_idx,
  input  logic [xlen-1:0]              buf_rd_pc,
  input  instr_class_e                 buf_rd_cls,
  input  logic [reg_addr_w-1:0]        buf_rd_rd_addr,
  input  logic [xlen-1:0]              buf_rd_rd_value,
  input  logic                         buf_rd_mem_hit,
  input  logic [xlen-1:0]              buf_rd_mem_addr,
  output logic                         buf_en,
  output logic                         buf_we,
  output logic [$clog2(buf_depth)-1:0] buf_idx,
  output logic [xlen-1:0]              buf_wr_pc,
  output instr_class_e                 buf_wr_cls,
  output logic [reg_addr_w-1:0]        buf_wr_rd_addr,
  output logic [xlen-1:0]              buf_wr_rd_value,
  output logic                         buf_wr_mem_hit,
  output logic [xlen-1:0]              buf_wr_mem_addr,
  output logic                         rd_valid,
  output logic [xlen-1:0]              rd_pc,
  output instr_class_e                 rd_cls,
  output logic [reg_addr_w-1:0]        rd_rd_addr,
  output logic [xlen-1:0]              rd_rd_value,
  output logic                         rd_mem_hit,
  output logic [xlen-1:0]              rd_mem_addr
);

  logic                         pend_valid;
  logic [$clog2(buf_depth)-1:0] pend_idx;
  logic                         accept;

  // a read goes through in any cycle the retire side leaves the port idle
  assign accept  = (pend_valid || rd_req) && !retire;
  assign buf_en  = retire || accept;
  assign buf_we  = retire;
  assign buf_idx = retire ? retire_idx : (pend_valid ? pend_idx : rd_idx);

  assign buf_wr_pc       = ret_pc;
  assign buf_wr_cls      = ret_cls;
  assign buf_wr_rd_addr  = ret_rd_addr;
  assign buf_wr_rd_value = ret_rd_value;
  assign buf_wr_mem_hit  = ret_mem_hit;
  assign buf_wr_mem_addr = ret_mem_addr;

  // buffer output register lines up with rd_valid
  assign rd_pc       = buf_rd_pc;
  assign rd_cls      = buf_rd_cls;
  assign rd_rd_addr  = buf_rd_rd_addr;
  assign rd_rd_value = buf_rd_rd_value;
  assign rd_mem_hit  = buf_rd_mem_hit;
  assign rd_mem_addr = buf_rd_mem_addr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_valid <= 1'b0;
      rd_valid   <= 1'b0;
    end else begin
      rd_valid   <= accept;
      pend_valid <= (pend_valid || rd_req) && !accept;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_req && !pend_valid) begin
      pend_idx <= rd_idx;
    end
  end

  a_single_pending: assert property (@(posedge clk) disable iff (!rst_n)
    rd_req |-> !pend_valid)
    else $error("host read requested while another read is still pending");

endmodule

// File: trace_buffer.sv
/* Circular trace record memory with one registered read/write port */
`timescale 1ns/1ps

module trace_buffer import trace_pkg::*; #(
  parameter int unsigned buf_depth = 16
) (
  input  logic                         clk,
  input  logic                         en,
  input  logic                         we,
  input  logic [$clog2(buf_depth)-1:0] idx,
  input  logic [xlen-1:0]              wr_pc,
  input  instr_class_e                 wr_cls,
  input  logic [reg_addr_w-1:0]        wr_rd_addr,
  input  logic [xlen-1:0]              wr_rd_value,
  input  logic                         wr_mem_hit,
  input  logic [xlen-1:0]              wr_mem_addr,
  output logic [xlen-1:0]              rd_pc,
  output instr_class_e                 rd_cls,
  output logic [reg_addr_w-1:0]        rd_rd_addr,
  output logic [xlen-1:0]              rd_rd_value,
  output logic                         rd_mem_hit,
  output logic [xlen-1:0]              rd_mem_addr
);

  logic [xlen-1:0]       m_pc       [buf_depth];
  instr_class_e          m_cls      [buf_depth];
  logic [reg_addr_w-1:0] m_rd_addr  [buf_depth];
  logic [xlen-1:0]       m_rd_value [buf_depth];
  logic                  m_mem_hit  [buf_depth];
  logic [xlen-1:0]       m_mem_addr [buf_depth];

  // read data only updates on a read access
  always_ff @(posedge clk) begin
    if (en && we) begin
      m_pc[idx]       <= wr_pc;
      m_cls[idx]      <= wr_cls;
      m_rd_addr[idx]  <= wr_rd_addr;
      m_rd_value[idx] <= wr_rd_value;
      m_mem_hit[idx]  <= wr_mem_hit;
      m_mem_addr[idx] <= wr_mem_addr;
    end else if (en) begin
      rd_pc       <= m_pc[idx];
      rd_cls      <= m_cls[idx];
      rd_rd_addr  <= m_rd_addr[idx];
      rd_rd_value <= m_rd_value[idx];
      rd_mem_hit  <= m_mem_hit[idx];
      rd_mem_addr <= m_mem_addr[idx];
    end
  end

endmodule

// File: instr_tracer.sv
/* Instruction trace unit top: classifier, EX and WB shadow stages,
   buffer arbiter and trace buffer */
`timescale 1ns/1ps

module instr_tracer import trace_pkg::*; #(
  parameter int unsigned ex_depth  = 4,
  parameter int unsigned wb_depth  = 4,
  parameter int unsigned buf_depth = 16
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         id_valid,
  input  logic                         is_decoding,
  input  logic [xlen-1:0]              pc,
  input  logic [xlen-1:0]              instr,
  input  logic                         ex_valid,
  input  logic                         wb_bypass,
  input  logic                         ex_reg_we,
  input  logic [reg_addr_w-1:0]        ex_reg_addr,
  input  logic [xlen-1:0]              ex_reg_wdata,
  input  logic                         ex_data_req,
  input  logic                         ex_data_gnt,
  input  logic [xlen-1:0]              ex_data_addr,
  input  logic                         wb_valid,
  input  logic                         wb_reg_we,
  input  logic [reg_addr_w-1:0]        wb_reg_addr,
  input  logic [xlen-1:0]              wb_reg_wdata,
  input  logic                         rd_req,
  input  logic [$clog2(buf_depth)-1:0] rd_idx,
  output logic                         rd_valid,
  output logic [xlen-1:0]              rd_pc,
  output instr_class_e                 rd_cls,
  output logic [reg_addr_w-1:0]        rd_rd_addr,
  output logic [xlen-1:0]              rd_rd_value,
  output logic                         rd_mem_hit,
  output logic [xlen-1:0]              rd_mem_addr,
  output logic [count_w-1:0]           trace_count
);

  localparam int unsigned idx_w = $clog2(buf_depth);

  logic                  issue;
  logic [xlen-1:0]       issue_pc;
  instr_class_e          issue_cls;
  logic [reg_addr_w-1:0] issue_rd;

  logic                  hand_off;
  logic [xlen-1:0]       ho_pc, ho_rd_value, ho_mem_addr;
  instr_class_e          ho_cls;
  logic [reg_addr_w-1:0] ho_rd_addr;
  logic                  ho_mem_hit;

  logic                  retire;
  logic [idx_w-1:0]      retire_idx;
  logic [xlen-1:0]       ret_pc, ret_rd_value, ret_mem_addr;
  instr_class_e          ret_cls;
  logic [reg_addr_w-1:0] ret_rd_addr;
  logic                  ret_mem_hit;

  logic                  buf_en, buf_we;
  logic [idx_w-1:0]      buf_idx;
  logic [xlen-1:0]       buf_wr_pc, buf_wr_rd_value, buf_wr_mem_addr;
  instr_class_e          buf_wr_cls;
  logic [reg_addr_w-1:0] buf_wr_rd_addr;
  logic                  buf_wr_mem_hit;
  logic [xlen-1:0]       buf_rd_pc, buf_rd_rd_value, buf_rd_mem_addr;
  instr_class_e          buf_rd_cls;
  logic [reg_addr_w-1:0] buf_rd_rd_addr;
  logic                  buf_rd_mem_hit;

  instr_classifier instr_classifier_i (
    .clk, .rst_n, .id_valid, .is_decoding, .pc, .instr,
    .issue, .issue_pc, .issue_cls, .issue_rd
  );

  trace_ex_stage #(.ex_depth(ex_depth)) trace_ex_stage_i (
    .clk, .rst_n, .issue, .issue_pc, .issue_cls, .issue_rd,
    .ex_valid, .wb_bypass, .ex_reg_we, .ex_reg_addr, .ex_reg_wdata,
    .ex_data_req, .ex_data_gnt, .ex_data_addr,
    .hand_off, .ho_pc, .ho_cls, .ho_rd_addr, .ho_rd_value, .ho_mem_hit, .ho_mem_addr
  );

  trace_wb_stage #(.wb_depth(wb_depth), .buf_depth(buf_depth)) trace_wb_stage_i (
    .clk, .rst_n,
    .hand_off, .ho_pc, .ho_cls, .ho_rd_addr, .ho_rd_value, .ho_mem_hit, .ho_mem_addr,
    .wb_valid, .wb_reg_we, .wb_reg_addr, .wb_reg_wdata,
    .retire, .retire_idx, .ret_pc, .ret_cls, .ret_rd_addr, .ret_rd_value,
    .ret_mem_hit, .ret_mem_addr, .trace_count
  );

  trace_arbiter #(.buf_depth(buf_depth)) trace_arbiter_i (
    .clk, .rst_n,
    .retire, .retire_idx, .ret_pc, .ret_cls, .ret_rd_addr, .ret_rd_value,
    .ret_mem_hit, .ret_mem_addr, .rd_req, .rd_idx,
    .buf_rd_pc, .buf_rd_cls, .buf_rd_rd_addr, .buf_rd_rd_value,
    .buf_rd_mem_hit, .buf_rd_mem_addr,
    .buf_en, .buf_we, .buf_idx, .buf_wr_pc, .buf_wr_cls, .buf_wr_rd_addr,
    .buf_wr_rd_value, .buf_wr_mem_hit, .buf_wr_mem_addr,
    .rd_valid, .rd_pc, .rd_cls, .rd_rd_addr, .rd_rd_value, .rd_mem_hit, .rd_mem_addr
  );

  trace_buffer #(.buf_depth(buf_depth)) trace_buffer_i (
    .clk, .en(buf_en), .we(buf_we), .idx(buf_idx),
    .wr_pc(buf_wr_pc), .wr_cls(buf_wr_cls), .wr_rd_addr(buf_wr_rd_addr),
    .wr_rd_value(buf_wr_rd_value), .wr_mem_hit(buf_wr_mem_hit), .wr_mem_addr(buf_wr_mem_addr),
    .rd_pc(buf_rd_pc), .rd_cls(buf_rd_cls), .rd_rd_addr(buf_rd_rd_addr),
    .rd_rd_value(buf_rd_rd_value), .rd_mem_hit(buf_rd_mem_hit), .rd_mem_addr(buf_rd_mem_addr)
  );

endmodule

// File: tb_instr_tracer.sv
/* Instruction tracer testbench: batch stimulus, reference decode model,
   buffer read-back compare and watchdog */
`timescale 1ns/1ps

module tb_instr_tracer import trace_pkg::*; ();

  localparam int unsigned buf_depth = 16;
  localparam int unsigned idx_w     = $clog2(buf_depth);
  localparam int          batch_max = 4;
  localparam int          rec_w     = 106;
  // 13 batches and 90 reads, with slack per item and a fixed margin
  localparam int          wd_cycles = 13 * 24 + 90 * 6 + 200;

  logic clk = 1'b0;
  logic rst_n;
  logic id_valid, is_decoding, ex_valid, wb_bypass, ex_reg_we, ex_data_req, ex_data_gnt;
  logic wb_valid, wb_reg_we, rd_req, rd_valid, rd_mem_hit;
  logic [xlen-1:0] pc, instr, ex_reg_wdata, ex_data_addr, wb_reg_wdata;
  logic [xlen-1:0] rd_pc, rd_rd_value, rd_mem_addr;
  logic [reg_addr_w-1:0] ex_reg_addr, wb_reg_addr, rd_rd_addr;
  logic [idx_w-1:0] rd_idx;
  logic [count_w-1:0] trace_count;
  instr_class_e rd_cls;

  // per-slot stimulus of the current batch
  logic [31:0] s_pc [batch_max];
  logic [31:0] s_instr [batch_max];
  logic [31:0] s_ex_data [batch_max];
  logic [31:0] s_maddr [batch_max];
  logic [31:0] s_wb_data [batch_max];
  logic [4:0]  s_ex_addr [batch_max];
  logic [4:0]  s_wb_addr [batch_max];
  logic s_ex_we [batch_max];
  logic s_req [batch_max];
  logic s_gnt [batch_max];
  logic s_bypass [batch_max];
  logic s_wb_we [batch_max];

  // {pc, cls, rd_addr, rd_value, mem_hit, mem_addr}
  logic [rec_w-1:0] exp_q [$];
  logic [rec_w-1:0] rd_exp_q [$];
  logic [31:0] lfsr = 32'd10;
  string cur_test;
  int n_checks = 0;
  int n_errors = 0;
  int n_tests = 0;
  int test_checks0, test_errors0;

  always #2 clk = ~clk;

  instr_tracer #(.ex_depth(4), .wb_depth(4), .buf_depth(buf_depth)) instr_tracer_i (
    .clk, .rst_n, .id_valid, .is_decoding, .pc, .instr,
    .ex_valid, .wb_bypass, .ex_reg_we, .ex_reg_addr, .ex_reg_wdata,
    .ex_data_req, .ex_data_gnt, .ex_data_addr,
    .wb_valid, .wb_reg_we, .wb_reg_addr, .wb_reg_wdata, .rd_req, .rd_idx,
    .rd_valid, .rd_pc, .rd_cls, .rd_rd_addr, .rd_rd_value, .rd_mem_hit, .rd_mem_addr,
    .trace_count
  );

  //////////////////////////////
  // random source and reference model

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    int k;
    r = 32'd0;
    for (k = 0; k < n; k++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return r;
  endfunction

  // sel 0..11 walk the classes, 12 and up give unknown opcodes
  function automatic logic [31:0] build_instr(input int sel);
    logic [31:0] hi, rdf;
    logic [2:0] f3;
    logic [6:0] op;
    hi = take_bits(17);
    rdf = take_bits(5);
    f3 = 3'(take_bits(3));
    case (sel)
      0: op = 7'b0110111;
      1: op = 7'b0010111;
      2: op = 7'b1101111;
      3: op = 7'b1100111;
      4: op = 7'b1100011;
      5: op = 7'b0000011;
      6: op = 7'b0100011;
      7: op = 7'b0010011;
      8: op = 7'b0110011;
      9: op = 7'b0001111;
      10: begin
        op = 7'b1110011;
        if (f3 == 3'd0) f3 = 3'd2;
      end
      11: begin
        op = 7'b1110011;
        f3 = 3'd0;
      end
      12: op = 7'b0000000;
      default: op = 7'b1111111;
    endcase
    return {hi[16:0], f3, rdf[4:0], op};
  endfunction

  // returns {class, rd_addr}
  function automatic logic [8:0] ref_decode(input logic [31:0] w);
    instr_class_e c;
    logic [4:0] rd;
    case (w[6:0])
      7'b0110111: c = cls_lui;
      7'b0010111: c = cls_auipc;
      7'b1101111: c = cls_jal;
      7'b1100111: c = cls_jalr;
      7'b1100011: c = cls_branch;
      7'b0000011: c = cls_load;
      7'b0100011: c = cls_store;
      7'b0010011: c = cls_alu_imm;
      7'b0110011: c = cls_alu_reg;
      7'b0001111: c = cls_fence;
      7'b1110011: c = (w[14:12] == 3'd0) ? cls_system : cls_csr;
      default:    c = cls_invalid;
    endcase
    rd = (c inside {cls_lui, cls_auipc, cls_jal, cls_jalr, cls_load, cls_alu_imm,
                    cls_alu_reg, cls_csr}) ? w[11:7] : 5'd0;
    return {c, rd};
  endfunction

  // last matching EX write, then last matching WB write, x0 stays 0
  function automatic logic [rec_w-1:0] expected_record(input int i);
    logic [8:0] dec;
    logic [4:0] rd;
    logic [31:0] val;
    logic hit;
    dec = ref_decode(s_instr[i]);
    rd = dec[4:0];
    val = 32'd0;
    if (s_ex_we[i] && s_ex_addr[i] == rd) val = s_ex_data[i];
    if (s_wb_we[i] && s_wb_addr[i] == rd) val = s_wb_data[i];
    if (rd == 5'd0) val = 32'd0;
    hit = s_req[i] && s_gnt[i];
    return {s_pc[i], dec[8:5], rd, val, hit, hit ? s_maddr[i] : 32'd0};
  endfunction

  task automatic fill_slot(input int i, input logic [31:0] w);
    s_instr[i] = w;
    s_pc[i] = take_bits(30) << 2;
    s_ex_we[i] = 1'b1;
    s_ex_addr[i] = w[11:7];
    s_ex_data[i] = take_bits(32);
    s_req[i] = 1'b0;
    s_gnt[i] = 1'b0;
    s_maddr[i] = take_bits(32);
    s_bypass[i] = 1'b0;
    s_wb_we[i] = 1'b0;
    s_wb_addr[i] = w[11:7];
    s_wb_data[i] = take_bits(32);
  endtask

  task automatic random_slot(input int i);
    logic [31:0] r;
    fill_slot(i, build_instr(int'(take_bits(4) % 14)));
    r = take_bits(6);
    s_ex_we[i] = r[0];
    s_req[i] = r[1];
    s_gnt[i] = r[2];
    s_bypass[i] = r[3];
    s_wb_we[i] = r[4];
    if (r[5]) s_wb_addr[i] = 5'(take_bits(5));
  endtask

  //////////////////////////////
  // stimulus: decode all slots, then EX exits, then WB retires

  task automatic run_batch(input int n);
    int i;
    for (i = 0; i < n; i++) begin
      @(posedge clk);
      id_valid <= 1'b1;
      is_decoding <= 1'b1;
      pc <= s_pc[i];
      instr <= s_instr[i];
    end
    @(posedge clk);
    id_valid <= 1'b0;
    is_decoding <= 1'b0;
    @(posedge clk);
    for (i = 0; i < n; i++) begin
      ex_valid <= !s_bypass[i];
      wb_bypass <= s_bypass[i];
      ex_reg_we <= s_ex_we[i];
      ex_reg_addr <= s_ex_addr[i];
      ex_reg_wdata <= s_ex_data[i];
      ex_data_req <= s_req[i];
      ex_data_gnt <= s_gnt[i];
      ex_data_addr <= s_maddr[i];
      @(posedge clk);
    end
    ex_valid <= 1'b0;
    wb_bypass <= 1'b0;
    ex_reg_we <= 1'b0;
    ex_data_req <= 1'b0;
    ex_data_gnt <= 1'b0;
    for (i = 0; i < n; i++) begin
      wb_valid <= 1'b1;
      wb_reg_we <= s_wb_we[i];
      wb_reg_addr <= s_wb_addr[i];
      wb_reg_wdata <= s_wb_data[i];
      exp_q.push_back(expected_record(i));
      @(posedge clk);
    end
    wb_valid <= 1'b0;
    wb_reg_we <= 1'b0;
    repeat (2) @(posedge clk);
  endtask

  task automatic check_field(input string field, input logic [31:0] exp,
                             input logic [31:0] act);
    n_checks++;
    assert (act === exp) else begin
      $display("MISMATCH %s %s: expected 0x%08h actual 0x%08h", cur_test, field, exp, act);
      n_errors++;
    end
  endtask

  task automatic read_entry(input int unsigned idx, input logic [rec_w-1:0] rec);
    int w;
    logic seen;
    @(posedge clk);
    rd_req <= 1'b1;
    rd_idx <= idx_w'(idx);
    rd_exp_q.push_back(rec);
    @(posedge clk);
    rd_req <= 1'b0;
    seen = 1'b0;
    w = 0;
    while (!seen && w < 16) begin
      @(negedge clk);
      seen = rd_valid;
      w++;
    end
    assert (seen) else begin
      $display("%s: read of buffer entry %0d never completed", cur_test, idx);
      n_errors++;
      rd_exp_q.delete();
    end
  endtask

  // compare every returned read against the record queued with it
  always @(negedge clk) begin : compare_reads
    logic [rec_w-1:0] rec;
    if (rst_n && rd_valid) begin
      assert (rd_exp_q.size() != 0) else begin
        $display("%s: rd_valid pulsed with no host read outstanding", cur_test);
        n_errors++;
      end
      if (rd_exp_q.size() != 0) begin
        rec = rd_exp_q.pop_front();
        check_field("pc", rec[105:74], rd_pc);
        check_field("cls", 32'(rec[73:70]), 32'(rd_cls));
        check_field("rd_addr", 32'(rec[69:65]), 32'(rd_rd_addr));
        check_field("rd_value", rec[64:33], rd_rd_value);
        check_field("mem_hit", 32'(rec[32]), 32'(rd_mem_hit));
        check_field("mem_addr", rec[31:0], rd_mem_addr);
      end
    end
  end

  // newest record first, as far back as the buffer reaches
  task automatic check_buffer();
    int total, n_show, k, n;
    total = exp_q.size();
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_field("trace_count", 32'(total % 65536), 32'(trace_count));
    n_show = (total < int'(buf_depth)) ? total : int'(buf_depth);
    for (k = 0; k < n_show; k++) begin
      n = total - 1 - k;
      read_entry(n % buf_depth, exp_q[n]);
    end
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    test_checks0 = n_checks;
    test_errors0 = n_errors;
  endtask

  task automatic finish_test();
    check_buffer();
    n_tests++;
    $display("test %s: %0d checks, %0d errors", cur_test,
             n_checks - test_checks0, n_errors - test_errors0);
  endtask

  //////////////////////////////
  // test sequence

  initial begin
    int g, b, i, k, n, base;
    rst_n = 1'b0;
    id_valid = 1'b0;
    is_decoding = 1'b0;
    pc = '0;
    instr = '0;
    ex_valid = 1'b0;
    wb_bypass = 1'b0;
    ex_reg_we = 1'b0;
    ex_reg_addr = '0;
    ex_reg_wdata = '0;
    ex_data_req = 1'b0;
    ex_data_gnt = 1'b0;
    ex_data_addr = '0;
    wb_valid = 1'b0;
    wb_reg_we = 1'b0;
    wb_reg_addr = '0;
    wb_reg_wdata = '0;
    rd_req = 1'b0;
    rd_idx = '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    begin_test("classify");
    // id_valid alone must not issue a record
    @(posedge clk);
    id_valid <= 1'b1;
    instr <= take_bits(32);
    @(posedge clk);
    id_valid <= 1'b0;
    for (g = 0; g < 14; g += batch_max) begin
      n = (14 - g < batch_max) ? 14 - g : batch_max;
      for (i = 0; i < n; i++) fill_slot(i, build_instr(g + i));
      run_batch(n);
    end
    finish_test();

    begin_test("ex_capture");
    fill_slot(0, build_instr(5));
    fill_slot(1, build_instr(6));
    fill_slot(2, build_instr(8));
    fill_slot(3, build_instr(5));
    s_req[0] = 1'b1;
    s_gnt[0] = 1'b1;
    s_req[1] = 1'b1;
    s_gnt[1] = 1'b1;
    s_ex_addr[2] = s_instr[2][11:7] ^ 5'd1;
    // request without grant
    s_req[3] = 1'b1;
    run_batch(4);
    finish_test();

    begin_test("wb_capture");
    fill_slot(0, build_instr(7));
    fill_slot(1, build_instr(8) & 32'hFFFFF07F);
    fill_slot(2, build_instr(5));
    fill_slot(3, build_instr(2));
    s_wb_we[0] = 1'b1;
    s_wb_we[1] = 1'b1;
    s_ex_we[2] = 1'b0;
    s_wb_we[2] = 1'b1;
    s_wb_we[3] = 1'b1;
    s_wb_addr[3] = s_instr[3][11:7] ^ 5'd1;
    run_batch(4);
    finish_test();

    begin_test("bypass");
    for (i = 0; i < batch_max; i++) begin
      random_slot(i);
      s_bypass[i] = (i != 1);
    end
    run_batch(4);
    finish_test();

    begin_test("wrap");
    for (b = 0; b < 5; b++) begin
      for (i = 0; i < batch_max; i++) random_slot(i);
      run_batch(4);
    end
    // host reads of older entries overlap the next retire burst
    base = exp_q.size();
    for (i = 0; i < batch_max; i++) random_slot(i);
    fork
      run_batch(4);
      for (k = 0; k < 12; k++) read_entry((base - 1 - k) % buf_depth, exp_q[base - 1 - k]);
    join
    finish_test();

    $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    #(wd_cycles * 4);
    $display("watchdog: run did not complete within %0d cycles", wd_cycles);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// File: src.f
trace_pkg.sv
instr_classifier.sv
trace_ex_stage.sv
trace_wb_stage.sv
trace_arbiter.sv
trace_buffer.sv
instr_tracer.sv
tb_instr_tracer.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the instruction tracer testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f src.f --top-module tb_instr_tracer -o sim_tb; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "NO ERRORS" sim.log; then
  exit 0
fi
exit 1
